// ==== all.f ====
+incdir+.
video_pkg.sv
video_if.sv
video_sig_gen.sv
pattern_gen.sv
video_out_stage.sv
video_out_top.sv
video_properties.sv
video_checker.sv
tb_video_out.sv

// ==== Bender.yml ====
package:
  name: video_out

sources:
  - include_dirs:
      - .
    files:
      - video_pkg.sv
      - video_if.sv
      - video_sig_gen.sv
      - pattern_gen.sv
      - video_out_stage.sv
      - video_out_top.sv
  - target: test
    files:
      - video_properties.sv
      - video_checker.sv
      - tb_video_out.sv

// ==== tb_video_out.sv ====
`timescale 1ns/10ps

module tb_video_out;

  localparam int ACT_H  = 32;
  localparam int H_FP   = 4;
  localparam int H_SYNC = 4;
  localparam int H_BP   = 8;
  localparam int ACT_V  = 16;
  localparam int V_FP   = 2;
  localparam int V_SYNC = 2;
  localparam int V_BP   = 4;
  localparam int FPS    = 4;

  localparam int FRAME_PIXELS =
    (ACT_H + H_FP + H_SYNC + H_BP) * (ACT_V + V_FP + V_SYNC + V_BP);
  localparam int N_FRAMES    = 12;
  localparam int CYCLE_LIMIT = (N_FRAMES + 2) * FRAME_PIXELS;

  logic        pixel_clk_in;
  logic        rst_in;
  logic [1:0]  pattern_sel;
  logic [23:0] solid_color;
  logic [7:0]  red;
  logic [7:0]  green;
  logic [7:0]  blue;
  logic        hs;
  logic        vs;
  logic        de;
  logic        frame_done;
  logic [23:0] frame_checksum;
  logic [5:0]  frame_count;

  int   frames_checked;
  int   frames_failed;
  int   error_count;
  logic coverage_ok;
  int   cycles;

  logic [15:0] lfsr = 16'd95;

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic take_bits(input int n, output logic [31:0] bits);
    bits = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      bits = {bits[30:0], lfsr[0]};
    end
  endtask

  video_out_top #(
    .ACTIVE_H_PIXELS(ACT_H),
    .H_FRONT_PORCH  (H_FP),
    .H_SYNC_WIDTH   (H_SYNC),
    .H_BACK_PORCH   (H_BP),
    .ACTIVE_LINES   (ACT_V),
    .V_FRONT_PORCH  (V_FP),
    .V_SYNC_WIDTH   (V_SYNC),
    .V_BACK_PORCH   (V_BP),
    .FPS            (FPS)
  ) i_video_out_top (
    .pixel_clk_in  (pixel_clk_in),
    .rst_in        (rst_in),
    .pattern_sel   (pattern_sel),
    .solid_color   (solid_color),
    .red           (red),
    .green         (green),
    .blue          (blue),
    .hs            (hs),
    .vs            (vs),
    .de            (de),
    .frame_done    (frame_done),
    .frame_checksum(frame_checksum),
    .frame_count   (frame_count)
  );

  video_checker #(
    .ACT_H(ACT_H), .H_FP(H_FP), .H_SYNC(H_SYNC), .H_BP(H_BP),
    .ACT_V(ACT_V), .V_FP(V_FP), .V_SYNC(V_SYNC), .V_BP(V_BP),
    .FPS(FPS)
  ) i_video_checker (
    .pixel_clk_in  (pixel_clk_in),
    .rst_in        (rst_in),
    .pattern_sel   (pattern_sel),
    .solid_color   (solid_color),
    .red           (red),
    .green         (green),
    .blue          (blue),
    .hs            (hs),
    .vs            (vs),
    .de            (de),
    .frame_done    (frame_done),
    .frame_checksum(frame_checksum),
    .frame_count   (frame_count),
    .frames_checked(frames_checked),
    .frames_failed (frames_failed),
    .error_count   (error_count),
    .coverage_ok   (coverage_ok)
  );

  bind video_out_top video_properties i_video_properties (.*);

  initial begin
    pixel_clk_in = 1'b0;
    forever #50 pixel_clk_in = ~pixel_clk_in;
  end

  // one change per frame window, always before the new-frame point
  initial begin : stimulus
    logic [31:0] r;
    int wait_cycles;
    @(negedge rst_in);
    for (int f = 0; f < N_FRAMES + 2; f++) begin
      take_bits(9, r);
      wait_cycles = r;
      repeat (wait_cycles) @(posedge pixel_clk_in);
      if (f < 4) begin
        pattern_sel <= 2'(f);  // walk all four patterns first
      end else begin
        take_bits(2, r);
        pattern_sel <= r[1:0];
      end
      take_bits(1, r);
      if (r[0]) begin
        take_bits(24, r);
        solid_color <= r[23:0];
      end
      repeat (FRAME_PIXELS - wait_cycles) @(posedge pixel_clk_in);
    end
  end

  initial begin
    rst_in = 1'b1;
    pattern_sel = 2'd0;
    solid_color = 24'd0;
    cycles = 0;
    repeat (4) @(posedge pixel_clk_in);
    rst_in <= 1'b0;
    while (frames_checked < N_FRAMES && cycles < CYCLE_LIMIT) begin
      @(posedge pixel_clk_in);
      cycles++;
    end
    if (frames_checked < N_FRAMES) begin
      $display("timeout after %0d cycles, only %0d of %0d frames finished",
               cycles, frames_checked, N_FRAMES);
    end
    if (coverage_ok !== 1'b1) begin
      $display("not every pattern and frame_count wrap was exercised");
    end
    $display("frames checked %0d, frames failed %0d, errors %0d",
             frames_checked, frames_failed, error_count);
    if (frames_checked >= N_FRAMES && frames_failed == 0 && error_count == 0 &&
        coverage_ok === 1'b1) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

// ==== video_checker.sv ====
`timescale 1ns/10ps

module video_checker #(
  parameter int ACT_H  = 32,
  parameter int H_FP   = 4,
  parameter int H_SYNC = 4,
  parameter int H_BP   = 8,
  parameter int ACT_V  = 16,
  parameter int V_FP   = 2,
  parameter int V_SYNC = 2,
  parameter int V_BP   = 4,
  parameter int FPS    = 4
) (
  input  logic        pixel_clk_in,
  input  logic        rst_in,
  input  logic [1:0]  pattern_sel,
  input  logic [23:0] solid_color,
  input  logic [7:0]  red,
  input  logic [7:0]  green,
  input  logic [7:0]  blue,
  input  logic        hs,
  input  logic        vs,
  input  logic        de,
  input  logic        frame_done,
  input  logic [23:0] frame_checksum,
  input  logic [5:0]  frame_count,
  output int          frames_checked,
  output int          frames_failed,
  output int          error_count,
  output logic        coverage_ok
);

  localparam int LINE  = ACT_H + H_FP + H_SYNC + H_BP;
  localparam int LINES = ACT_V + V_FP + V_SYNC + V_BP;

  typedef struct packed {
    logic        hs;
    logic        vs;
    logic        de;
    logic        fd;    // frame_done due on this cycle
    logic [1:0]  fsel;  // pattern of the frame just closed
    logic [23:0] rgb;
    logic [23:0] csum;
  } expect_t;

  expect_t dly [3];  // dly[2] is due at the outputs now
  int h;
  int v;
  int fc;
  logic [1:0]  sel;      // select in force for this frame
  logic [1:0]  act_sel;
  logic [23:0] solid;
  logic [23:0] acc;      // running checksum
  logic nf;
  logic last;
  int de_cnt;
  int frame_errs;
  int errs = 0;
  int frames = 0;
  int fails = 0;
  logic [3:0] pat_seen = 4'd0;
  logic wrap_seen = 1'b0;

  function automatic logic [23:0] bar_color(input logic [2:0] idx);
    case (idx)
      3'd0: return 24'hFFFFFF;
      3'd1: return 24'hFFFF00;
      3'd2: return 24'h00FFFF;
      3'd3: return 24'h00FF00;
      3'd4: return 24'hFF00FF;
      3'd5: return 24'hFF0000;
      3'd6: return 24'h0000FF;
      default: return 24'h000000;
    endcase
  endfunction

  function automatic logic [23:0] pattern_rgb(input logic [1:0] s, input int x,
                                              input int y, input int f,
                                              input logic [23:0] sc);
    case (s)
      2'd0: return bar_color(x[6:4]);  // bars 16 px wide
      2'd1: return (x[3] ^ y[3]) ? 24'hFFFFFF : 24'h000000;
      2'd2: return {x[7:0], y[7:0], f[5:0], 2'b00};
      default: return sc;
    endcase
  endfunction

  function automatic string pattern_name(input logic [1:0] s);
    case (s)
      2'd0: return "bars";
      2'd1: return "checker";
      2'd2: return "gradient";
      default: return "solid";
    endcase
  endfunction

  task report_mismatch(input string name, input logic [23:0] got, input logic [23:0] exp);
    $display("ERROR %s in frame %0d: got 0x%h, expected 0x%h", name, frames, got, exp);
    errs++;
    frame_errs++;
  endtask

  task close_frame;
    if (frame_checksum !== dly[2].csum) begin
      report_mismatch("frame_checksum", frame_checksum, dly[2].csum);
    end
    if (de_cnt != ACT_H * ACT_V) begin
      $display("frame %0d: de was high on %0d cycles instead of %0d",
               frames, de_cnt, ACT_H * ACT_V);
      errs++;
      frame_errs++;
    end
    if (frame_errs == 0) begin
      $display("frame %0d %s: ok, checksum 0x%h", frames, pattern_name(dly[2].fsel),
               frame_checksum);
    end else begin
      $display("frame %0d %s: %0d errors", frames, pattern_name(dly[2].fsel), frame_errs);
      fails++;
    end
    pat_seen[dly[2].fsel] = 1'b1;
    frames++;
    de_cnt = 0;
    frame_errs = 0;
  endtask

  task compare_outputs;
    if (hs !== dly[2].hs) report_mismatch("hs", 24'(hs), 24'(dly[2].hs));
    if (vs !== dly[2].vs) report_mismatch("vs", 24'(vs), 24'(dly[2].vs));
    if (de !== dly[2].de) report_mismatch("de", 24'(de), 24'(dly[2].de));
    if (frame_done !== dly[2].fd) begin
      report_mismatch("frame_done", 24'(frame_done), 24'(dly[2].fd));
    end
    if ({red, green, blue} !== dly[2].rgb) begin
      report_mismatch("rgb", {red, green, blue}, dly[2].rgb);
    end
    if (frame_count !== 6'(fc)) report_mismatch("frame_count", 24'(frame_count), 24'(fc));
    if (dly[2].fd) close_frame();
    if (de === 1'b1) de_cnt++;  // counted after close, belongs to the new frame
  endtask

  task push_expected;
    expect_t e;
    e = '0;
    e.hs = (h >= ACT_H + H_FP) && (h < ACT_H + H_FP + H_SYNC);
    e.vs = (v >= ACT_V + V_FP) && (v < ACT_V + V_FP + V_SYNC);
    e.de = (h < ACT_H) && (v < ACT_V);
    e.fd = last;
    if (last) begin
      e.csum = acc;
      e.fsel = act_sel;
      acc = 24'd0;
    end
    if (e.de) begin
      e.rgb = pattern_rgb(sel, h, v, fc, solid);
      act_sel = sel;
      acc = acc + e.rgb;
    end
    dly[2] = dly[1];
    dly[1] = dly[0];
    dly[0] = e;
  endtask

  task step_model;
    if (nf) begin
      sel = pattern_sel;    // takes effect for the next frame
      solid = solid_color;
    end
    nf = (h == ACT_H - 1) && (v == ACT_V);
    if (nf) begin
      if (fc == FPS - 1) begin
        fc = 0;
        wrap_seen = 1'b1;
      end else begin
        fc++;
      end
    end
    last = (h == LINE - 1) && (v == LINES - 1);
    if (h == LINE - 1) begin
      h = 0;
      v = (v == LINES - 1) ? 0 : v + 1;
    end else begin
      h++;
    end
  endtask

  always @(posedge pixel_clk_in) begin
    if (rst_in) begin
      h = 0;
      v = 0;
      fc = 0;
      sel = 2'd0;
      act_sel = 2'd0;
      solid = 24'd0;
      acc = 24'd0;
      nf = 1'b0;
      last = 1'b0;
      de_cnt = 0;
      frame_errs = 0;
      for (int i = 0; i < 3; i++) dly[i] = '0;  // outputs held low after reset
    end else begin
      compare_outputs();
      push_expected();
      step_model();
    end
    frames_checked <= frames;
    frames_failed  <= fails;
    error_count    <= errs;
    coverage_ok    <= (&pat_seen) && wrap_seen;
  end

endmodule

// ==== video_properties.sv ====
`timescale 1ns/10ps

module video_properties (
  input logic       pixel_clk_in,
  input logic       rst_in,
  input logic [7:0] red,
  input logic [7:0] green,
  input logic [7:0] blue,
  input logic       hs,
  input logic       de,
  input logic       frame_done
);

  // horizontal sync lives in the blanking interval
  hs_in_blanking: assert property (
    @(posedge pixel_clk_in) disable iff (rst_in)
    !(hs && de)
  ) else $error("hs and de high on the same cycle");

  frame_done_single: assert property (
    @(posedge pixel_clk_in) disable iff (rst_in)
    frame_done |=> !frame_done
  ) else $error("frame_done held for more than one cycle");

  // blanked pixels carry no color
  rgb_blanked: assert property (
    @(posedge pixel_clk_in) disable iff (rst_in)
    !de |-> ({red, green, blue} == 24'd0)
  ) else $error("rgb not zero while de is low");

endmodule

// ==== video_out_top.sv ====
`timescale 1ns/10ps
`include "video_config.svh"

module video_out_top
  import video_pkg::*;
#(
  parameter int ACTIVE_H_PIXELS = `VIDEO_ACTIVE_H,
  parameter int H_FRONT_PORCH   = `VIDEO_H_FP,
  parameter int H_SYNC_WIDTH    = `VIDEO_H_SYNC,
  parameter int H_BACK_PORCH    = `VIDEO_H_BP,
  parameter int ACTIVE_LINES    = `VIDEO_ACTIVE_V,
  parameter int V_FRONT_PORCH   = `VIDEO_V_FP,
  parameter int V_SYNC_WIDTH    = `VIDEO_V_SYNC,
  parameter int V_BACK_PORCH    = `VIDEO_V_BP,
  parameter int FPS             = `VIDEO_FPS
) (
  input  logic        pixel_clk_in,
  input  logic        rst_in,
  input  logic [1:0]  pattern_sel,
  input  logic [23:0] solid_color,
  output logic [7:0]  red,
  output logic [7:0]  green,
  output logic [7:0]  blue,
  output logic        hs,
  output logic        vs,
  output logic        de,
  output logic        frame_done,
  output logic [23:0] frame_checksum,
  output logic [5:0]  frame_count
);

  video_if vid_bus ();

  pattern_sel_e sel;
  pixel_word_u  solid;
  pixel_word_u  pix;
  logic         hs_d;
  logic         vs_d;
  logic         ad_d;
  logic         nf_d;
  logic         last_px_d;

  assign sel   = pattern_sel_e'(pattern_sel);
  assign solid = solid_color;

  video_sig_gen #(
    .ACTIVE_H_PIXELS(ACTIVE_H_PIXELS),
    .H_FRONT_PORCH  (H_FRONT_PORCH),
    .H_SYNC_WIDTH   (H_SYNC_WIDTH),
    .H_BACK_PORCH   (H_BACK_PORCH),
    .ACTIVE_LINES   (ACTIVE_LINES),
    .V_FRONT_PORCH  (V_FRONT_PORCH),
    .V_SYNC_WIDTH   (V_SYNC_WIDTH),
    .V_BACK_PORCH   (V_BACK_PORCH),
    .FPS            (FPS)
  ) i_video_sig_gen (
    .pixel_clk_in(pixel_clk_in),
    .rst_in      (rst_in),
    .vid         (vid_bus.src),
    .frame_count (frame_count)
  );

  pattern_gen i_pattern_gen (
    .pixel_clk_in(pixel_clk_in),
    .rst_in      (rst_in),
    .vid         (vid_bus.snk),
    .frame_count (frame_count),
    .pattern_sel (sel),
    .solid_color (solid),
    .pix         (pix),
    .hs_d        (hs_d),
    .vs_d        (vs_d),
    .ad_d        (ad_d),
    .nf_d        (nf_d),
    .last_px_d   (last_px_d)
  );

  video_out_stage i_video_out_stage (
    .pixel_clk_in  (pixel_clk_in),
    .rst_in        (rst_in),
    .pix           (pix),
    .hs_d          (hs_d),
    .vs_d          (vs_d),
    .ad_d          (ad_d),
    .nf_d          (nf_d),
    .last_px_d     (last_px_d),
    .red           (red),
    .green         (green),
    .blue          (blue),
    .hs            (hs),
    .vs            (vs),
    .de            (de),
    .frame_done    (frame_done),
    .frame_checksum(frame_checksum)
  );

endmodule

// ==== video_out_stage.sv ====
`timescale 1ns/10ps

module video_out_stage
  import video_pkg::*;
(
  input  logic        pixel_clk_in,
  input  logic        rst_in,
  input  pixel_word_u pix,
  input  logic        hs_d,
  input  logic        vs_d,
  input  logic        ad_d,
  input  logic        nf_d,
  input  logic        last_px_d,
  output logic [7:0]  red,
  output logic [7:0]  green,
  output logic [7:0]  blue,
  output logic        hs,
  output logic        vs,
  output logic        de,
  output logic        frame_done,
  output logic [23:0] frame_checksum
);

  logic [23:0] sum;       // running total of this frame
  logic [23:0] sum_held;  // total frozen at start of vblank

  // syncs and colour, blanked outside the active area
  always_ff @(posedge pixel_clk_in) begin
    if (rst_in) begin
      hs    <= 1'b0;
      vs    <= 1'b0;
      de    <= 1'b0;
      red   <= '0;
      green <= '0;
      blue  <= '0;
    end else begin
      hs    <= hs_d;
      vs    <= vs_d;
      de    <= ad_d;
      red   <= ad_d ? pix.rgb.red   : 8'd0;
      green <= ad_d ? pix.rgb.green : 8'd0;
      blue  <= ad_d ? pix.rgb.blue  : 8'd0;
    end
  end

  // frame checksum
  // no active pixels arrive between nf_d and last_px_d, so the
  // total is already final at the start of vertical blanking
  always_ff @(posedge pixel_clk_in) begin
    if (rst_in) begin
      sum            <= '0;
      sum_held       <= '0;
      frame_done     <= 1'b0;
      frame_checksum <= '0;
    end else begin
      frame_done <= last_px_d;
      if (nf_d) sum_held <= sum;
      if (last_px_d) begin
        frame_checksum <= sum_held;  // published with frame_done
        sum            <= ad_d ? pix.raw : '0;  // first pixel of the next frame
      end else if (ad_d) begin
        sum <= sum + pix.raw;  // wraps mod 2^24
      end
    end
  end

endmodule

// ==== pattern_gen.sv ====
`timescale 1ns/10ps
`include "video_config.svh"

module pattern_gen
  import video_pkg::*;
(
  input  logic         pixel_clk_in,
  input  logic         rst_in,
  video_if.snk         vid,
  input  logic [5:0]   frame_count,
  input  pattern_sel_e pattern_sel,
  input  pixel_word_u  solid_color,
  output pixel_word_u  pix,
  output logic         hs_d,
  output logic         vs_d,
  output logic         ad_d,
  output logic         nf_d,
  output logic         last_px_d
);

  // the output stage adds the last clock of the pipe
  localparam int FLAG_LAT = `VIDEO_PIPE_DEPTH - 1;

  pattern_sel_e sel_q;    // select for the frame being drawn
  pixel_word_u  solid_q;  // colour for the frame being drawn

  pattern_sel_e s1_sel;
  logic [7:0]   s1_a;     // bar index, checker bit or h byte
  logic [7:0]   s1_b;     // v byte for the gradient
  logic [5:0]   s1_fc;
  pixel_word_u  s1_solid;

  logic [4:0] flag_pipe [FLAG_LAT];

  // both picked up during vertical blanking only
  always_ff @(posedge pixel_clk_in) begin
    if (rst_in) begin
      sel_q <= pat_bars;
    end else if (vid.nf) begin
      sel_q <= pattern_sel;
    end
  end

  always_ff @(posedge pixel_clk_in) begin
    if (vid.nf) solid_q <= solid_color;
  end

  // stage one, position to pattern index
  always_ff @(posedge pixel_clk_in) begin
    s1_sel   <= sel_q;
    s1_fc    <= frame_count;
    s1_solid <= solid_q;
    s1_b     <= vid.vcount[7:0];
    case (sel_q)
      pat_bars:     s1_a <= {5'd0, vid.hcount[6:4]};  // 16 px wide bars
      pat_checker:  s1_a <= {7'd0, vid.hcount[3] ^ vid.vcount[3]};
      pat_gradient: s1_a <= vid.hcount[7:0];
      default:      s1_a <= '0;
    endcase
  end

  // stage two, index to colour
  always_ff @(posedge pixel_clk_in) begin
    case (s1_sel)
      pat_bars:    pix <= BAR_COLORS[s1_a[2:0]];
      pat_checker: pix.raw <= s1_a[0] ? 24'hFF_FF_FF : 24'h00_00_00;
      pat_gradient: begin
        pix.rgb.red   <= s1_a;
        pix.rgb.green <= s1_b;
        pix.rgb.blue  <= {s1_fc, 2'b00};  // blue steps with the frame
      end
      default:     pix <= s1_solid;
    endcase
  end

  // flags ride alongside the colour path
  always_ff @(posedge pixel_clk_in) begin
    if (rst_in) begin
      for (int i = 0; i < FLAG_LAT; i++) flag_pipe[i] <= '0;
    end else begin
      flag_pipe[0] <= {vid.hs, vid.vs, vid.ad, vid.nf, vid.last_px};
      for (int i = 1; i < FLAG_LAT; i++) flag_pipe[i] <= flag_pipe[i-1];
    end
  end

  assign {hs_d, vs_d, ad_d, nf_d, last_px_d} = flag_pipe[FLAG_LAT-1];

endmodule

// ==== video_sig_gen.sv ====
`timescale 1ns/10ps
`include "video_config.svh"

module video_sig_gen #(
  parameter int ACTIVE_H_PIXELS = `VIDEO_ACTIVE_H,
  parameter int H_FRONT_PORCH   = `VIDEO_H_FP,
  parameter int H_SYNC_WIDTH    = `VIDEO_H_SYNC,
  parameter int H_BACK_PORCH    = `VIDEO_H_BP,
  parameter int ACTIVE_LINES    = `VIDEO_ACTIVE_V,
  parameter int V_FRONT_PORCH   = `VIDEO_V_FP,
  parameter int V_SYNC_WIDTH    = `VIDEO_V_SYNC,
  parameter int V_BACK_PORCH    = `VIDEO_V_BP,
  parameter int FPS             = `VIDEO_FPS
) (
  input  logic       pixel_clk_in,
  input  logic       rst_in,
  video_if.src       vid,
  output logic [5:0] frame_count
);

  localparam int LINE_LENGTH =
    ACTIVE_H_PIXELS + H_FRONT_PORCH + H_SYNC_WIDTH + H_BACK_PORCH;
  localparam int TOTAL_LINES =
    ACTIVE_LINES + V_FRONT_PORCH + V_SYNC_WIDTH + V_BACK_PORCH;

  // all window edges sized to the count bus
  localparam logic [`VIDEO_CNT_W-1:0] LAST_H = `VIDEO_CNT_W'(LINE_LENGTH - 1);
  localparam logic [`VIDEO_CNT_W-1:0] LAST_V = `VIDEO_CNT_W'(TOTAL_LINES - 1);
  localparam logic [`VIDEO_CNT_W-1:0] ACT_H  = `VIDEO_CNT_W'(ACTIVE_H_PIXELS);
  localparam logic [`VIDEO_CNT_W-1:0] ACT_V  = `VIDEO_CNT_W'(ACTIVE_LINES);

  localparam logic [`VIDEO_CNT_W-1:0] H_SYNC_START =
    `VIDEO_CNT_W'(ACTIVE_H_PIXELS + H_FRONT_PORCH);
  localparam logic [`VIDEO_CNT_W-1:0] H_SYNC_END =
    `VIDEO_CNT_W'(ACTIVE_H_PIXELS + H_FRONT_PORCH + H_SYNC_WIDTH);
  localparam logic [`VIDEO_CNT_W-1:0] V_SYNC_START =
    `VIDEO_CNT_W'(ACTIVE_LINES + V_FRONT_PORCH);
  localparam logic [`VIDEO_CNT_W-1:0] V_SYNC_END =
    `VIDEO_CNT_W'(ACTIVE_LINES + V_FRONT_PORCH + V_SYNC_WIDTH);

  localparam logic [5:0] LAST_FRAME = 6'(FPS - 1);

  logic line_end;    // last pixel of any line
  logic raster_end;  // last pixel of the last line
  logic vblank_hit;  // last active column on the first blanking line

  assign line_end   = (vid.hcount == LAST_H);
  assign raster_end = line_end && (vid.vcount == LAST_V);
  assign vblank_hit = (vid.hcount == ACT_H - 1'b1) && (vid.vcount == ACT_V);

  // syncs and active area decode straight from the counts
  assign vid.hs = (vid.hcount >= H_SYNC_START) && (vid.hcount < H_SYNC_END);
  assign vid.vs = (vid.vcount >= V_SYNC_START) && (vid.vcount < V_SYNC_END);
  assign vid.ad = (vid.hcount < ACT_H) && (vid.vcount < ACT_V);

  // raster counters
  always_ff @(posedge pixel_clk_in) begin
    if (rst_in) begin
      vid.hcount <= '0;
      vid.vcount <= '0;
    end else if (line_end) begin
      vid.hcount <= '0;
      if (vid.vcount == LAST_V) begin
        vid.vcount <= '0;  // wrap to top left
      end else begin
        vid.vcount <= vid.vcount + 1'b1;
      end
    end else begin
      vid.hcount <= vid.hcount + 1'b1;
    end
  end

  // frame markers, one cycle after the position that triggers them
  always_ff @(posedge pixel_clk_in) begin
    if (rst_in) begin
      vid.nf      <= 1'b0;
      vid.last_px <= 1'b0;
      frame_count <= '0;
    end else begin
      vid.nf      <= vblank_hit;
      vid.last_px <= raster_end;
      if (vblank_hit) begin
        frame_count <= (frame_count == LAST_FRAME) ? 6'd0 : frame_count + 6'd1;
      end
    end
  end

endmodule

// ==== video_if.sv ====
`timescale 1ns/10ps
`include "video_config.svh"

interface video_if;

  logic [`VIDEO_CNT_W-1:0] hcount;  // pixel within line
  logic [`VIDEO_CNT_W-1:0] vcount;  // line within frame
  logic hs;       // horizontal sync, active high
  logic vs;       // vertical sync, active high
  logic ad;       // inside the active area
  logic nf;       // start of vertical blanking
  logic last_px;  // raster just wrapped

  // timing generator side
  modport src (
    output hcount, vcount,
    output hs, vs, ad,
    output nf, last_px
  );

  // consumer side
  modport snk (
    input hcount, vcount,
    input hs, vs, ad,
    input nf, last_px
  );

endinterface

// ==== video_pkg.sv ====
`include "video_config.svh"

package video_pkg;

  // one pixel word, seen either as channels or as a plain number
  typedef union packed {
    struct packed {
      logic [7:0] red;
      logic [7:0] green;
      logic [7:0] blue;
    } rgb;
    logic [`VIDEO_PIX_W-1:0] raw;  // checksum view
  } pixel_word_u;

  // test image choice
  typedef enum logic [1:0] {
    pat_bars     = 2'd0,
    pat_checker  = 2'd1,
    pat_gradient = 2'd2,
    pat_solid    = 2'd3
  } pattern_sel_e;

  typedef pixel_word_u bar_table_t [0:7];

  // classic eight bars, brightest on the left
  localparam bar_table_t BAR_COLORS = '{
    24'hFF_FF_FF,  // white
    24'hFF_FF_00,  // yellow
    24'h00_FF_FF,  // cyan
    24'h00_FF_00,  // green
    24'hFF_00_FF,  // magenta
    24'hFF_00_00,  // red
    24'h00_00_FF,  // blue
    24'h00_00_00   // black
  };

endpackage

// ==== video_config.svh ====
`ifndef VIDEO_CONFIG_SVH
`define VIDEO_CONFIG_SVH

// default raster is 1280x720 at 60 frames per second
`define VIDEO_ACTIVE_H 1280
`define VIDEO_H_FP 110
`define VIDEO_H_SYNC 40
`define VIDEO_H_BP 220

`define VIDEO_ACTIVE_V 720
`define VIDEO_V_FP 5
`define VIDEO_V_SYNC 5
`define VIDEO_V_BP 20

`define VIDEO_FPS 60

// width of the hcount and vcount buses, enough for 1650 pixels per line
`define VIDEO_CNT_W 11

// one pixel, three 8-bit channels
`define VIDEO_PIX_W 24

// registered count to output pixel, in clocks
`define VIDEO_PIPE_DEPTH 3

`endif
